// File: files.f
fruPkg.sv
fruInputLatch.sv
fruMirrorPipe.sv
fruRegFile.sv
fruOperandForward.sv
fru.sv
fruTb.sv

// File: fru.sv
`timescale 1ns/1ps

// forwarding register unit, top level
// operands and stall request are valid one cycle after the inputs are presented
module fru #(
   parameter int regCount = 32          // implemented registers
) (
   input  logic              sys_clk,
   input  logic              rstN,
   input  fruPkg::pcuCtrlT   pcuCtrl,   // steps and works from control unit
   input  fruPkg::regAddrT   regA,      // source addresses from decoder
   input  fruPkg::regAddrT   regB,
   input  fruPkg::stageResT  exuRes,    // EXU result bus
   input  fruPkg::stageResT  mauRes,    // MAU result bus
   input  fruPkg::decodeT    decode,
   output fruPkg::dataT      opd1,      // operands to EXU
   output fruPkg::dataT      opd2,
   output logic              waitForData   // stall request to control unit
);

   fruPkg::pcuCtrlT  ctrlL;
   fruPkg::regAddrT  regAL, regBL;
   fruPkg::stageResT exuResL, mauResL;
   fruPkg::decodeT   decodeL;
   fruPkg::stageResT wbStage;     // write-back mirror stage
   logic             exuIsLoad;   // EXU holds a load
   fruPkg::dataT     rdDataA, rdDataB;

   ////////////////////////////////////////
   // input latch and mirror pipe
   ////////////////////////////////////////
   fruInputLatch u_inLatch (
      .sys_clk(sys_clk), .rstN(rstN),
      .pcuCtrl(pcuCtrl), .regA(regA), .regB(regB),
      .exuRes(exuRes), .mauRes(mauRes), .decode(decode),
      .ctrlL(ctrlL), .regAL(regAL), .regBL(regBL),
      .exuResL(exuResL), .mauResL(mauResL), .decodeL(decodeL)
   );

   fruMirrorPipe u_mirror (
      .sys_clk(sys_clk), .rstN(rstN),
      .ctrlL(ctrlL), .decodeL(decodeL), .mauResL(mauResL),
      .exuIsLoad(exuIsLoad), .wbStage(wbStage)
   );

   ////////////////////////////////////////
   // register file and forwarding
   ////////////////////////////////////////
   fruRegFile #(.regCount(regCount)) u_regFile (
      .sys_clk(sys_clk), .rstN(rstN),
      .wbStage(wbStage), .workWb(ctrlL.workWb),
      .rdAddrA(regAL), .rdAddrB(regBL),
      .rdDataA(rdDataA), .rdDataB(rdDataB)
   );

   fruOperandForward u_fwd (
      .regAL(regAL), .regBL(regBL), .ctrlL(ctrlL),
      .exuResL(exuResL), .mauResL(mauResL), .wbStage(wbStage),
      .exuIsLoad(exuIsLoad), .rdDataA(rdDataA), .rdDataB(rdDataB),
      .opd1(opd1), .opd2(opd2), .waitForData(waitForData)
   );

endmodule

// File: fruInputLatch.sv
`timescale 1ns/1ps

// input register stage of the forwarding unit
// steps and works come from combinational logic in the control unit and settle late,
// so everything is sampled once here and held for the whole cycle
module fruInputLatch (
   input  logic              sys_clk,
   input  logic              rstN,
   input  fruPkg::pcuCtrlT   pcuCtrl,
   input  fruPkg::regAddrT   regA,
   input  fruPkg::regAddrT   regB,
   input  fruPkg::stageResT  exuRes,
   input  fruPkg::stageResT  mauRes,
   input  fruPkg::decodeT    decode,
   output fruPkg::pcuCtrlT   ctrlL,
   output fruPkg::regAddrT   regAL,
   output fruPkg::regAddrT   regBL,
   output fruPkg::stageResT  exuResL,
   output fruPkg::stageResT  mauResL,
   output fruPkg::decodeT    decodeL
);

   ////////////////////////////////////////
   // control and addresses
   ////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge rstN) begin
      if (!rstN) begin
         ctrlL   <= '0;               // no step, no work
         regAL   <= '0;               // invalid address
         regBL   <= '0;
         decodeL <= '0;               // not a load
      end else begin
         ctrlL   <= pcuCtrl;
         regAL   <= regA;             // operand A address from decoder
         regBL   <= regB;             // operand B address from decoder
         decodeL <= decode;
      end
   end

   ////////////////////////////////////////
   // stage results
   ////////////////////////////////////////
   // cleared too, so a stale dest can't match right after reset
   always_ff @(posedge sys_clk or negedge rstN) begin
      if (!rstN) begin
         exuResL <= '0;
         mauResL <= '0;
      end else begin
         exuResL <= exuRes;           // EXU result bus, forwarding only
         mauResL <= mauRes;           // MAU result bus, forwarding and write-back
      end
   end

endmodule

// File: fruMirrorPipe.sv
`timescale 1ns/1ps

// shadow of the pipeline stages the unit still needs to track
// EXU only carries a load flag, write-back carries the full result
module fruMirrorPipe (
   input  logic              sys_clk,
   input  logic              rstN,
   input  fruPkg::pcuCtrlT   ctrlL,
   input  fruPkg::decodeT    decodeL,
   input  fruPkg::stageResT  mauResL,
   output logic              exuIsLoad,
   output fruPkg::stageResT  wbStage
);

   logic isLoad;   // decoded instruction is a load

   // a load is a memory access that is not a store
   assign isLoad = decodeL.mem & decodeL.memAcc & ~decodeL.memSt;

   ////////////////////////////////////////
   // EXU mirror
   ////////////////////////////////////////
   // data of a load only shows up in MAU, so EXU must not forward it
   always_ff @(posedge sys_clk or negedge rstN) begin
      if (!rstN) begin
         exuIsLoad <= 1'b0;
      end else if (ctrlL.stepExu) begin
         exuIsLoad <= isLoad;           // follows the instruction into EXU
      end
   end

   ////////////////////////////////////////
   // write-back mirror
   ////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge rstN) begin
      if (!rstN) begin
         wbStage <= '0;                 // dest invalid, nothing to write
      end else if (ctrlL.stepWb) begin
         wbStage <= mauResL;            // dest, cond and data move as one
      end
   end

endmodule

// File: fruOperandForward.sv
`timescale 1ns/1ps

// operand select and forwarding
// newest copy of each source register wins: EXU, then MAU, then write-back,
// then the register file, r31 always reads zero
module fruOperandForward (
   input  fruPkg::regAddrT   regAL,
   input  fruPkg::regAddrT   regBL,
   input  fruPkg::pcuCtrlT   ctrlL,
   input  fruPkg::stageResT  exuResL,
   input  fruPkg::stageResT  mauResL,
   input  fruPkg::stageResT  wbStage,
   input  logic              exuIsLoad,
   input  fruPkg::dataT      rdDataA,
   input  fruPkg::dataT      rdDataB,
   output fruPkg::dataT      opd1,
   output fruPkg::dataT      opd2,
   output logic              waitForData
);

   fruPkg::srcSelE selA;   // source of operand 1
   fruPkg::srcSelE selB;   // source of operand 2
   logic           exuHitA;   // operand A address matches the EXU dest
   logic           exuHitB;

   // address compare shared by every path
   // both valid, same index, and never r31
   function automatic logic addrHit(input fruPkg::regAddrT src, input fruPkg::regAddrT dest);
      addrHit = src.valid & dest.valid & (src.idx == dest.idx)
              & (src.idx != fruPkg::zeroRegIdx);
   endfunction

   // priority pick of one operand source
   function automatic fruPkg::srcSelE pickSrc(input fruPkg::regAddrT src);
      fruPkg::srcSelE sel;
      sel = fruPkg::selReg;                                   // default, register file
      if (addrHit(src, exuResL.dest) && ctrlL.workExu && !exuIsLoad && exuResL.cond) begin
         sel = fruPkg::selExu;                                // ALU result, newest
      end else if (addrHit(src, mauResL.dest) && ctrlL.workMau && mauResL.cond) begin
         sel = fruPkg::selMau;
      end else if (addrHit(src, wbStage.dest) && ctrlL.workWb && wbStage.cond) begin
         sel = fruPkg::selWb;                                 // not yet in the file
      end
      return sel;
   endfunction

   ////////////////////////////////////////
   // source select
   ////////////////////////////////////////
   always_comb begin
      selA = pickSrc(regAL);
      selB = pickSrc(regBL);
   end

   ////////////////////////////////////////
   // load-use stall request
   ////////////////////////////////////////
   // load data only exists after MAU, so the control unit must hold EXU a cycle
   assign exuHitA = addrHit(regAL, exuResL.dest);
   assign exuHitB = addrHit(regBL, exuResL.dest);
   assign waitForData = ctrlL.workExu & exuIsLoad & (exuHitA | exuHitB);

   ////////////////////////////////////////
   // operand muxes
   ////////////////////////////////////////
   always_comb begin
      unique case (selA)
         fruPkg::selExu: opd1 = exuResL.data;
         fruPkg::selMau: opd1 = mauResL.data;
         fruPkg::selWb:  opd1 = wbStage.data;
         default:        opd1 = rdDataA;
      endcase
      if (regAL.idx == fruPkg::zeroRegIdx) opd1 = '0;        // r31, valid or not

      unique case (selB)
         fruPkg::selExu: opd2 = exuResL.data;
         fruPkg::selMau: opd2 = mauResL.data;
         fruPkg::selWb:  opd2 = wbStage.data;
         default:        opd2 = rdDataB;
      endcase
      if (regBL.idx == fruPkg::zeroRegIdx) opd2 = '0;
   end

endmodule

// File: fruPkg.sv
package fruPkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////
   localparam int dataW   = 32;         // integer data path
   localparam int regIdxW = 5;          // 32 architectural registers

   localparam logic [regIdxW-1:0] zeroRegIdx = 5'd31;   // r31 always reads zero

   typedef logic [dataW-1:0] dataT;

   // register address with its valid bit, valid low means no compare and no write
   typedef struct packed {
      logic               valid;
      logic [regIdxW-1:0] idx;
   } regAddrT;

   // one stage result, from EXU or from MAU
   typedef struct packed {
      regAddrT dest;    // destination register
      logic    cond;    // low only for a false conditional move
      dataT    data;    // result value
   } stageResT;

   // the only decode bits needed here
   typedef struct packed {
      logic mem;        // memory instruction
      logic memAcc;     // accesses memory
      logic memSt;      // store, so not a load
   } decodeT;

   // level controls from the pipeline control unit
   typedef struct packed {
      logic stepExu;    // EXU takes a new instruction
      logic stepWb;     // write-back takes the MAU result
      logic workExu;    // EXU holds real work
      logic workMau;    // MAU holds real work
      logic workWb;     // write-back holds real work
   } pcuCtrlT;

   // operand source, ordered by priority
   typedef enum logic [1:0] {
      selReg = 2'd0,
      selWb  = 2'd1,
      selMau = 2'd2,
      selExu = 2'd3
   } srcSelE;

endpackage

// File: fruRegFile.sv
`timescale 1ns/1ps

// architectural register file
// one clocked write port fed by write-back, two combinational read ports
module fruRegFile #(
   parameter int regCount = 32          // implemented registers, 1 to 32
) (
   input  logic              sys_clk,
   input  logic              rstN,
   input  fruPkg::stageResT  wbStage,
   input  logic              workWb,
   input  fruPkg::regAddrT   rdAddrA,
   input  fruPkg::regAddrT   rdAddrB,
   output fruPkg::dataT      rdDataA,
   output fruPkg::dataT      rdDataB
);

   fruPkg::dataT regs [regCount];       // register storage
   logic         wrEn;                  // write-back commits this cycle

   // real work, condition true, and a valid in-range dest
   assign wrEn = workWb & wbStage.cond & wbStage.dest.valid
               & (int'(wbStage.dest.idx) < regCount);

   ////////////////////////////////////////
   // write port
   ////////////////////////////////////////
   always_ff @(posedge sys_clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;                          // whole file cleared at once
         end
      end else if (wrEn) begin
         regs[wbStage.dest.idx] <= wbStage.data;
      end
   end

   ////////////////////////////////////////
   // read ports
   ////////////////////////////////////////
   // a write in the same cycle isn't seen here, the WB forward path covers it
   always_comb begin
      rdDataA = '0;                                 // invalid or out of range
      rdDataB = '0;
      if (rdAddrA.valid && (int'(rdAddrA.idx) < regCount)) rdDataA = regs[rdAddrA.idx];
      if (rdAddrB.valid && (int'(rdAddrB.idx) < regCount)) rdDataB = regs[rdAddrB.idx];
   end

endmodule

// File: fruTb.sv
`timescale 1ns/1ps

// testbench for the forwarding register unit
// each row is presented for one clock and its operands checked after the next edge
module fruTb;

   // one stimulus row, as seen on the DUT inputs
   typedef struct packed {
      fruPkg::pcuCtrlT  ctrl;   // stepExu, stepWb, workExu, workMau, workWb
      fruPkg::regAddrT  a;
      fruPkg::regAddrT  b;
      fruPkg::stageResT exu;
      fruPkg::stageResT mau;
      fruPkg::decodeT   dec;
   } rowT;

   localparam fruPkg::decodeT aluOp   = 3'b000;   // no memory access
   localparam fruPkg::decodeT loadOp  = 3'b110;   // mem, memAcc, not store
   localparam fruPkg::decodeT storeOp = 3'b111;

   logic              sys_clk;
   logic              rstN;
   fruPkg::pcuCtrlT   pcuCtrl;
   fruPkg::regAddrT   regA, regB;
   fruPkg::stageResT  exuRes, mauRes;
   fruPkg::decodeT    decode;
   fruPkg::dataT      opd1, opd2;
   logic              waitForData;

   rowT          rows [$];        // stimulus table
   string        names [$];       // row names, same order
   integer       seed;
   logic         tableReady = 1'b0;
   int           rowErrs;         // mismatches in the current row
   int           passCount = 0;
   int           failCount = 0;

   // reference model state
   fruPkg::dataT     regM [32];
   fruPkg::stageResT wbM;         // write-back stage copy
   logic             ldM;         // EXU holds a load
   rowT              prevRow;     // bundle latched one edge earlier

   fru #(.regCount(32)) u_dut (
      .sys_clk(sys_clk), .rstN(rstN),
      .pcuCtrl(pcuCtrl), .regA(regA), .regB(regB),
      .exuRes(exuRes), .mauRes(mauRes), .decode(decode),
      .opd1(opd1), .opd2(opd2), .waitForData(waitForData)
   );

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;   // 40 ns period
   end

   ////////////////////////////////////////
   // table helpers
   ////////////////////////////////////////
   function automatic fruPkg::regAddrT src(input int v, input int idx);
      src.valid = (v != 0);
      src.idx   = 5'(idx);
   endfunction

   function automatic fruPkg::stageResT res(input int v, input int idx, input int c,
                                             input fruPkg::dataT d);
      res.dest = src(v, idx);
      res.cond = (c != 0);   // low for a false conditional move
      res.data = d;
   endfunction

   task automatic addRow(input string n, input fruPkg::pcuCtrlT c, input fruPkg::regAddrT a,
                         input fruPkg::regAddrT b, input fruPkg::stageResT e,
                         input fruPkg::stageResT m, input fruPkg::decodeT d);
      rowT r;
      r.ctrl = c;
      r.a    = a;
      r.b    = b;
      r.exu  = e;
      r.mau  = m;
      r.dec  = d;
      rows.push_back(r);
      names.push_back(n);
   endtask

   task automatic buildTable();
      fruPkg::stageResT none;
      none = '0;
      addRow("resetRead", 5'b00000, src(1, 3), src(1, 7), none, none, aluOp);
      // write-back path
      addRow("wbStepR5", 5'b01010, src(1, 5), src(0, 0), none, res(1, 5, 1, $random(seed)), aluOp);
      addRow("wbWorkR5", 5'b00001, src(1, 5), src(1, 1), none, none, aluOp);
      addRow("wbGap", 5'b00000, src(1, 1), src(1, 2), none, none, aluOp);
      addRow("readBackR5", 5'b00000, src(1, 5), src(1, 6), none, none, aluOp);
      addRow("condLowStep", 5'b01010, src(1, 5), src(0, 5), none, res(1, 5, 0, $random(seed)),
             aluOp);
      addRow("condLowWork", 5'b00001, src(1, 5), src(1, 4), none, none, aluOp);
      addRow("condLowGap", 5'b00000, src(1, 8), src(1, 5), none, none, aluOp);
      addRow("keepOldR5", 5'b00000, src(1, 5), src(1, 5), none, none, aluOp);
      // priority EXU > MAU > WB > file
      addRow("prioSetupWb", 5'b01000, src(1, 9), src(1, 0), none, res(1, 9, 1, $random(seed)),
             aluOp);
      addRow("prioAll", 5'b00111, src(1, 9), src(0, 9), res(1, 9, 1, $random(seed)),
             res(1, 9, 1, $random(seed)), aluOp);
      // steps a new WB value, so next row WB and the file hold different r9 data
      addRow("prioNoExu", 5'b01011, src(1, 9), src(0, 9), res(1, 9, 1, $random(seed)),
             res(1, 9, 1, $random(seed)), aluOp);
      addRow("prioNoMau", 5'b00001, src(1, 9), src(1, 9), res(1, 9, 1, $random(seed)),
             res(1, 9, 1, $random(seed)), aluOp);
      addRow("prioInvalidSrc", 5'b00111, src(0, 9), src(1, 9), res(1, 9, 1, $random(seed)),
             res(1, 9, 1, $random(seed)), aluOp);
      // load-use stall
      addRow("loadEnterExu", 5'b10000, src(1, 2), src(1, 9), none, none, loadOp);
      addRow("loadUseA", 5'b00110, src(1, 12), src(1, 3), res(1, 12, 1, $random(seed)),
             res(1, 12, 1, $random(seed)), aluOp);
      addRow("loadUseB", 5'b00100, src(1, 3), src(1, 12), res(1, 12, 1, $random(seed)), none,
             aluOp);
      addRow("storeEnterExu", 5'b10000, src(1, 2), src(1, 3), none, none, storeOp);
      addRow("storeNoStall", 5'b00100, src(1, 12), src(1, 3), res(1, 12, 1, $random(seed)), none,
             aluOp);
      addRow("loadAgain", 5'b10000, src(1, 2), src(1, 3), none, none, loadOp);
      addRow("aluEnterExu", 5'b10100, src(1, 12), src(1, 3), res(1, 12, 1, $random(seed)), none,
             aluOp);
      addRow("aluNoStall", 5'b00100, src(1, 3), src(1, 12), res(1, 12, 1, $random(seed)), none,
             aluOp);
      // register 31
      addRow("r31WbStep", 5'b01010, src(1, 31), src(0, 31), none,
             res(1, 31, 1, $random(seed)), aluOp);
      addRow("r31Forward", 5'b00111, src(1, 31), src(1, 31), res(1, 31, 1, $random(seed)),
             res(1, 31, 1, $random(seed)), aluOp);
      addRow("r31Gap", 5'b00000, src(1, 4), src(1, 5), none, none, aluOp);
      addRow("r31ReadBack", 5'b00000, src(1, 31), src(0, 31), none, none, aluOp);
      addRow("r31LoadEnter", 5'b10000, src(1, 2), src(1, 3), none, none, loadOp);
      addRow("r31LoadNoStall", 5'b00100, src(1, 31), src(1, 31), res(1, 31, 1, $random(seed)),
             none, aluOp);
   endtask

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic logic sameReg(input fruPkg::regAddrT s, input fruPkg::regAddrT d);
      return s.valid && d.valid && (s.idx == d.idx);
   endfunction

   // clock edge effects of the bundle that was latched one edge earlier
   task automatic advanceModel(input rowT p);
      if (p.ctrl.workWb && wbM.cond && wbM.dest.valid) regM[wbM.dest.idx] = wbM.data;
      if (p.ctrl.stepWb) wbM = p.mau;
      if (p.ctrl.stepExu) ldM = p.dec.mem && p.dec.memAcc && !p.dec.memSt;
   endtask

   function automatic fruPkg::dataT expectOpd(input fruPkg::regAddrT s, input rowT r);
      if (s.idx == fruPkg::zeroRegIdx) return '0;   // r31 is zero, valid or not
      if (sameReg(s, r.exu.dest) && r.ctrl.workExu && !ldM && r.exu.cond) return r.exu.data;
      if (sameReg(s, r.mau.dest) && r.ctrl.workMau && r.mau.cond) return r.mau.data;
      if (sameReg(s, wbM.dest) && r.ctrl.workWb && wbM.cond) return wbM.data;
      if (!s.valid) return '0;
      return regM[s.idx];
   endfunction

   function automatic logic expectStall(input rowT r);
      logic hitA;
      logic hitB;
      hitA = sameReg(r.a, r.exu.dest) && (r.a.idx != fruPkg::zeroRegIdx);
      hitB = sameReg(r.b, r.exu.dest) && (r.b.idx != fruPkg::zeroRegIdx);
      return r.ctrl.workExu && ldM && (hitA || hitB);
   endfunction

   task automatic compare(input string n, input string what, input logic [31:0] expVal,
                          input logic [31:0] actVal);
      if (actVal !== expVal) begin
         $display("ERROR %s %s: expected %h, actual %h", n, what, expVal, actVal);
         rowErrs++;
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      rstN    = 1'b0;
      pcuCtrl = '0;
      regA    = '0;
      regB    = '0;
      exuRes  = '0;
      mauRes  = '0;
      decode  = '0;
      seed    = 32'hfae63178;
      for (int k = 0; k < 32; k++) regM[k] = '0;
      wbM     = '0;
      ldM     = 1'b0;
      prevRow = '0;             // reset clears the latched bundle
      buildTable();
      tableReady = 1'b1;

      repeat (10) @(posedge sys_clk);
      #2 rstN = 1'b1;

      for (int i = 0; i < rows.size(); i++) begin
         pcuCtrl = rows[i].ctrl;   // 2 ns after the edge
         regA    = rows[i].a;
         regB    = rows[i].b;
         exuRes  = rows[i].exu;
         mauRes  = rows[i].mau;
         decode  = rows[i].dec;
         @(posedge sys_clk);
         #2;
         advanceModel(prevRow);
         rowErrs = 0;
         compare(names[i], "opd1", expectOpd(rows[i].a, rows[i]), opd1);
         compare(names[i], "opd2", expectOpd(rows[i].b, rows[i]), opd2);
         compare(names[i], "waitForData", 32'(expectStall(rows[i])), 32'(waitForData));
         if (rowErrs == 0) passCount++;
         else failCount++;
         $display("row %0d %s: %s", i, names[i], (rowErrs == 0) ? "ok" : "mismatch");
         prevRow = rows[i];
      end

      $display("%0d rows run, %0d passed, %0d failed", rows.size(), passCount, failCount);
      if (failCount == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // watchdog, sized from the table length
   initial begin
      wait (tableReady == 1'b1);
      #((rows.size() + 20) * 40);
      $display("timeout: the rows did not finish in the expected time");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module fruTb -f files.f -o fruSim \
   && ./obj_dir/fruSim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: build or simulation failed"; exit 1; }
